/* design/memOpPkg.sv */
package memOpPkg;

  // width of the data path and of one memory word
  localparam int dataWidth = 64;

  // byte lanes per word
  localparam int laneCount = dataWidth / 8;

  // funct3 width code of a RISC-V load or store
  // bit 2 set means the loaded field is zero-extended
  // code 7 has no name and falls into the double case everywhere
  typedef enum logic [2:0] {
    opB  = 3'd0,
    opH  = 3'd1,
    opW  = 3'd2,
    opD  = 3'd3,
    opBU = 3'd4,
    opHU = 3'd5,
    opWU = 3'd6
  } memOp_t;

  // one memory word
  typedef logic [dataWidth-1:0] data_t;

  // one enable bit per byte lane
  typedef logic [laneCount-1:0] mask_t;

  // byte position inside a word, the low address bits
  typedef logic [$clog2(laneCount)-1:0] offset_t;

endpackage

/* design/lsuPkg.sv */
package lsuPkg;

  import memOpPkg::*;

  // decode stage to memory stage
  // rdEn and wrEn are never both set, a store wins in the decode stage
  typedef struct packed {
    logic    rdEn;
    logic    wrEn;
    // word index, already wrapped to the memory depth
    logic [31:0] wordIdx;
    // byte lanes written by a store
    mask_t   wmask;
    // store data replicated over all lanes
    data_t   wrWord;
    // width code and offset travel on for the load stage
    memOp_t  memOp;
    offset_t offset;
  } memAccess_t;

  // memory stage to load stage
  typedef struct packed {
    // a load completed its read this cycle
    logic    valid;
    // full word as read from the RAM
    data_t   rdWord;
    memOp_t  memOp;
    offset_t offset;
  } memResp_t;

endpackage

/* design/accessDecode.sv */
`timescale 1ns/10ps

module accessDecode #(
  parameter int depthLog2 = 8
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                memRd,
  input  logic                memWr,
  input  logic [63:0]         addr,
  input  memOpPkg::memOp_t    memOp,
  input  memOpPkg::data_t     wrData,
  output lsuPkg::memAccess_t  accessQ
);
  import memOpPkg::*;

  // combinational decode of the incoming request
  offset_t     offsetD;
  mask_t       wmaskD;
  data_t       wrWordD;
  logic [31:0] wordIdxD;

  // control flops, cleared by reset
  logic rdEnQ;
  logic wrEnQ;

  // payload flops, loaded only with a request
  logic [31:0] wordIdxQ;
  mask_t       wmaskQ;
  data_t       wrWordQ;
  memOp_t      memOpQ;
  offset_t     offsetQ;

  // byte position in the word
  assign offsetD = addr[2:0];

  // word index wraps modulo the memory depth
  assign wordIdxD = 32'(addr[3 +: depthLog2]);

  // lane mask and replicated data from the width code
  // misaligned half/word/double accesses simply drop the low offset bits
  always_comb begin
    case (memOp)
      opB, opBU: begin
        // single lane at the offset
        wmaskD  = mask_t'(1) << offsetD;
        wrWordD = {laneCount{wrData[7:0]}};
      end
      opH, opHU: begin
        // lane pair picked by addr[2:1]
        wmaskD  = mask_t'(2'b11) << {offsetD[2:1], 1'b0};
        wrWordD = {(laneCount / 2){wrData[15:0]}};
      end
      opW, opWU: begin
        // lower or upper half of the word, addr[2]
        wmaskD  = mask_t'(4'hf) << {offsetD[2], 2'b00};
        wrWordD = {(laneCount / 4){wrData[31:0]}};
      end
      default: begin
        // double and code 7, the whole word
        wmaskD  = '1;
        wrWordD = wrData;
      end
    endcase
  end

  // strobes, store has priority when both are high
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdEnQ <= 1'b0;
      wrEnQ <= 1'b0;
    end else begin
      rdEnQ <= memRd & ~memWr;
      wrEnQ <= memWr;
    end
  end

  // payload only moves when there is a request to carry
  always_ff @(posedge clk) begin
    if (memRd || memWr) begin
      wordIdxQ <= wordIdxD;
      wmaskQ   <= wmaskD;
      wrWordQ  <= wrWordD;
      memOpQ   <= memOp;
      offsetQ  <= offsetD;
    end
  end

  // stage output
  always_comb begin
    accessQ.rdEn    = rdEnQ;
    accessQ.wrEn    = wrEnQ;
    accessQ.wordIdx = wordIdxQ;
    accessQ.wmask   = wmaskQ;
    accessQ.wrWord  = wrWordQ;
    accessQ.memOp   = memOpQ;
    accessQ.offset  = offsetQ;
  end

endmodule

/* design/dataMem.sv */
`timescale 1ns/10ps

module dataMem #(
  parameter int depthLog2 = 8
) (
  input  logic                clk,
  input  logic                rstN,
  input  lsuPkg::memAccess_t  accessQ,
  output lsuPkg::memResp_t    respQ
);
  import memOpPkg::*;

  localparam int depth = 2 ** depthLog2;

  // storage, contents are undefined after power up
  data_t mem [depth];

  logic [depthLog2-1:0] wordAddr;

  // response flops
  logic    validQ;
  data_t   rdWordQ;
  memOp_t  memOpQ;
  offset_t offsetQ;

  // decode stage already wrapped the index
  assign wordAddr = accessQ.wordIdx[depthLog2-1:0];

  // store, one byte lane at a time
  always_ff @(posedge clk) begin
    if (accessQ.wrEn) begin
      for (int lane = 0; lane < laneCount; lane++) begin
        if (accessQ.wmask[lane]) begin
          mem[wordAddr][lane*8 +: 8] <= accessQ.wrWord[lane*8 +: 8];
        end
      end
    end
  end

  // load, registered read of the whole word
  // width and offset go along for the format stage
  always_ff @(posedge clk) begin
    if (accessQ.rdEn) begin
      rdWordQ <= mem[wordAddr];
      memOpQ  <= accessQ.memOp;
      offsetQ <= accessQ.offset;
    end
  end

  // one pulse per completed read
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= accessQ.rdEn;
    end
  end

  always_comb begin
    respQ.valid  = validQ;
    respQ.rdWord = rdWordQ;
    respQ.memOp  = memOpQ;
    respQ.offset = offsetQ;
  end

endmodule

/* design/loadFormat.sv */
`timescale 1ns/10ps

module loadFormat (
  input  logic              clk,
  input  logic              rstN,
  input  lsuPkg::memResp_t  respQ,
  output logic              rdValid,
  output memOpPkg::data_t   rdData
);
  import memOpPkg::*;

  // candidate fields of the read word
  logic [7:0]  byteField;
  logic [15:0] halfField;
  logic [31:0] wordField;

  // extended result before the output register
  data_t loadValue;

  // field select, same lane rules as the decode stage
  always_comb begin
    // byte at the exact offset
    byteField = respQ.rdWord[{respQ.offset, 3'b000} +: 8];
    // half picked by offset[2:1], offset[0] is ignored
    halfField = respQ.rdWord[{respQ.offset[2:1], 4'b0000} +: 16];
    // word picked by offset[2], offset[1:0] are ignored
    wordField = respQ.rdWord[{respQ.offset[2], 5'b00000} +: 32];
  end

  // extension by width code
  always_comb begin
    case (respQ.memOp)
      opB: begin
        // sign-extend byte
        loadValue = {{(dataWidth - 8){byteField[7]}}, byteField};
      end
      opBU: begin
        loadValue = {{(dataWidth - 8){1'b0}}, byteField};
      end
      opH: begin
        // sign-extend half
        loadValue = {{(dataWidth - 16){halfField[15]}}, halfField};
      end
      opHU: begin
        loadValue = {{(dataWidth - 16){1'b0}}, halfField};
      end
      opW: begin
        // sign-extend word
        loadValue = {{(dataWidth - 32){wordField[31]}}, wordField};
      end
      opWU: begin
        loadValue = {{(dataWidth - 32){1'b0}}, wordField};
      end
      default: begin
        // double and code 7 pass the whole word
        loadValue = respQ.rdWord;
      end
    endcase
  end

  // result register
  // rdData holds its last value between loads
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdValid <= 1'b0;
      rdData  <= '0;
    end else begin
      rdValid <= respQ.valid;
      if (respQ.valid) begin
        rdData <= loadValue;
      end
    end
  end

endmodule

/* design/lsuTop.sv */
`timescale 1ns/10ps

module lsuTop #(
  // memory depth in words is 2**depthLog2
  parameter int depthLog2 = 8
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              memRd,
  input  logic              memWr,
  input  logic [63:0]       addr,
  input  memOpPkg::memOp_t  memOp,
  input  memOpPkg::data_t   wrData,
  output logic              rdValid,
  output memOpPkg::data_t   rdData
);
  import lsuPkg::*;

  // decode to memory
  memAccess_t accessQ;

  // memory to load format
  memResp_t respQ;

  // stage 1, mask and replicated store data
  accessDecode #(
    .depthLog2 (depthLog2)
  ) uDecode (
    .clk     (clk),
    .rstN    (rstN),
    .memRd   (memRd),
    .memWr   (memWr),
    .addr    (addr),
    .memOp   (memOp),
    .wrData  (wrData),
    .accessQ (accessQ)
  );

  // stage 2, byte-masked RAM with registered read
  dataMem #(
    .depthLog2 (depthLog2)
  ) uMem (
    .clk     (clk),
    .rstN    (rstN),
    .accessQ (accessQ),
    .respQ   (respQ)
  );

  // stage 3, field select and extension
  loadFormat uFormat (
    .clk     (clk),
    .rstN    (rstN),
    .respQ   (respQ),
    .rdValid (rdValid),
    .rdData  (rdData)
  );

endmodule

/* bench/lsuTb.sv */
`timescale 1ns/10ps

module lsuTb;
  import memOpPkg::*;

  localparam int clkPeriod = 40;

  // requests issued by each test, sized to the loops below
  localparam int doubleCount    = 15;
  localparam int byteLaneCount  = 32;
  localparam int extensionCount = 74;
  localparam int alignCount     = 9;
  localparam int streamCount    = 200;
  // stream test fills all 64 words first
  localparam int streamTotal    = 64 + streamCount;
  localparam int totalRequests  = doubleCount + byteLaneCount + extensionCount
                                  + alignCount + streamTotal;

  logic     clk;
  logic     rstN;
  logic     memRd;
  logic     memWr;
  logic [63:0] addr;
  memOp_t   memOp;
  data_t    wrData;
  logic     rdValid;
  data_t    rdData;

  // byte-addressed reference memory, 64 words of 8 bytes
  logic [7:0] refMem [512];

  // expected load results in issue order, with the cycle they must appear in
  logic [63:0] expDataQ [$];
  int          expCycleQ [$];

  int     cycleCount;
  integer seed;

  lsuTop #(
    .depthLog2 (6)
  ) UUT (
    .clk     (clk),
    .rstN    (rstN),
    .memRd   (memRd),
    .memWr   (memWr),
    .addr    (addr),
    .memOp   (memOp),
    .wrData  (wrData),
    .rdValid (rdValid),
    .rdData  (rdData)
  );

  initial begin
    clk = 1'b0;
  end

  always #(clkPeriod / 2) clk = ~clk;

  // rising edges seen so far
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Fail %s actual 0x%h expected 0x%h", name, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // bytes touched by a width code, code 7 counts as double
  function automatic int accessSize(input logic [2:0] code);
    case (code[1:0])
      2'd0: return 1;
      2'd1: return 2;
      2'd2: return 4;
      default: return 8;
    endcase
  endfunction

  // low offset bits below the access size are dropped
  function automatic int alignedStart(input logic [63:0] a, input int size);
    return int'(a[2:0]) & ~(size - 1);
  endfunction

  task automatic storeModel(input logic [63:0] a, input logic [2:0] code,
                            input logic [63:0] d);
    int size;
    int start;
    int base;
    size  = accessSize(code);
    start = alignedStart(a, size);
    // word base wraps modulo 512 bytes
    base  = int'(a[8:3]) * 8;
    for (int i = 0; i < size; i++) begin
      refMem[base + start + i] = d[8*i +: 8];
    end
  endtask

  function automatic logic [63:0] loadModel(input logic [63:0] a, input logic [2:0] code);
    int size;
    int start;
    int base;
    logic [63:0] value;
    size  = accessSize(code);
    start = alignedStart(a, size);
    base  = int'(a[8:3]) * 8;
    value = '0;
    for (int i = 0; i < size; i++) begin
      value[8*i +: 8] = refMem[base + start + i];
    end
    // codes 0 to 2 sign-extend, 4 to 6 zero-extend
    if (code[2] == 1'b0 && size < 8) begin
      for (int b = size * 8; b < 64; b++) begin
        value[b] = value[size*8 - 1];
      end
    end
    return value;
  endfunction

  // one request for one cycle, called 2 ns after a rising edge
  task automatic sendRequest(input logic rd, input logic wr, input logic [63:0] a,
                             input logic [2:0] code, input logic [63:0] d);
    memRd  = rd;
    memWr  = wr;
    addr   = a;
    memOp  = memOp_t'(code);
    wrData = d;
    // a store wins when both strobes are set
    if (wr) begin
      storeModel(a, code, d);
    end else if (rd) begin
      expDataQ.push_back(loadModel(a, code));
      // result shows up three edges after the strobe is driven
      expCycleQ.push_back(cycleCount + 3);
    end
    @(posedge clk);
    #2;
    memRd = 1'b0;
    memWr = 1'b0;
  endtask

  task automatic storeReq(input logic [63:0] a, input logic [2:0] code,
                          input logic [63:0] d);
    sendRequest(1'b0, 1'b1, a, code, d);
  endtask

  task automatic loadReq(input logic [63:0] a, input logic [2:0] code);
    sendRequest(1'b1, 1'b0, a, code, 64'h0);
  endtask

  // load result monitor, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rstN === 1'b1) begin
      if (rdValid === 1'b1) begin
        if (expDataQ.size() == 0) begin
          $display("rdValid pulsed while no load was outstanding");
          $display("Test failed");
          $fatal(1);
        end else begin
          checkValue("rdData", rdData, expDataQ.pop_front());
          checkValue("rdValid cycle", 64'(cycleCount), 64'(expCycleQ.pop_front()));
        end
      end else if (rdValid !== 1'b0) begin
        $display("rdValid is unknown after reset");
        $display("Test failed");
        $fatal(1);
      end else if (expCycleQ.size() != 0 && expCycleQ[0] <= cycleCount) begin
        $display("a load result did not arrive three cycles after its request");
        $display("Test failed");
        $fatal(1);
      end
    end
  end

  task automatic testReset();
    // outputs stay cleared while reset is held
    repeat (2) begin
      @(posedge clk);
      #2;
      checkValue("rdValid", 64'(rdValid), 64'h0);
      checkValue("rdData", rdData, 64'h0);
    end
    rstN = 1'b1;
    // and with no requests after release
    repeat (4) begin
      @(posedge clk);
      #2;
      checkValue("rdValid", 64'(rdValid), 64'h0);
      checkValue("rdData", rdData, 64'h0);
    end
  endtask

  task automatic testDouble();
    for (int i = 0; i < 6; i++) begin
      storeReq(64'(i) * 64'h48, opD, {$random(seed), $random(seed)});
    end
    for (int i = 0; i < 6; i++) begin
      loadReq(64'(i) * 64'h48, opD);
    end
    // upper address bits fall away, this lands on word 1
    storeReq(64'hffff_ffff_ffff_fe08, opD, 64'h0bad_cafe_f00d_d00d);
    loadReq(64'h0000_0000_0000_0008, opD);
    // word 9 seen through an address one depth higher
    loadReq(64'h0000_0000_0000_0248, opD);
  endtask

  task automatic testByteLanes();
    logic [2:0] code;
    for (int off = 0; off < 8; off++) begin
      code = (off % 2 == 0) ? 3'd0 : 3'd4;
      storeReq(64'h60, opD, 64'h0011_2233_4455_6677);
      // junk in the upper bytes of wrData must stay out of the other lanes
      storeReq(64'h60 + 64'(off), code, {$random(seed), 24'h0, 8'ha0 + 8'(off)});
      loadReq(64'h60, opD);
      loadReq(64'h60 + 64'(off), opBU);
    end
  endtask

  task automatic testExtension();
    // every byte, half and word has its top bit set
    storeReq(64'ha0, opD, 64'hf1e2_d3c4_b5a6_9788);
    // and here every top bit is clear
    storeReq(64'ha8, opD, 64'h7162_5344_3526_1708);
    for (int code = 0; code < 8; code++) begin
      for (int off = 0; off < 8; off++) begin
        loadReq(64'ha0 + 64'(off), 3'(code));
      end
      loadReq(64'ha8 + 64'(code), 3'(code));
    end
  endtask

  task automatic testAlignment();
    storeReq(64'h100, opD, 64'h1111_2222_3333_4444);
    // offset 3 word store covers lanes 0 to 3
    storeReq(64'h103, opW, 64'h5555_5555_cafe_babe);
    // offset 5 half store covers lanes 4 and 5
    storeReq(64'h105, opH, 64'h7777_6666_9999_8001);
    loadReq(64'h100, opD);
    loadReq(64'h101, opW);
    loadReq(64'h106, opWU);
    loadReq(64'h107, opH);
    loadReq(64'h103, opHU);
    loadReq(64'h105, opW);
  endtask

  task automatic testStream();
    logic [31:0] r;
    logic [63:0] a;
    logic [63:0] lastAddr;
    // known contents everywhere, so random loads never read an unwritten word
    for (int w = 0; w < 64; w++) begin
      storeReq(64'(w) << 3, opD, {8{2'b10, 6'(w)}} ^ 64'h5a3c_96e1_0f78_c3a5);
    end
    lastAddr = '0;
    for (int n = 0; n < streamCount; n++) begin
      r = $random(seed);
      a = {$random(seed), $random(seed)};
      // one in four hits the word of the previous request, one cycle later
      if (r[3:2] == 2'b00) begin
        a = {lastAddr[63:3], a[2:0]};
      end
      case (r[1:0])
        2'b00, 2'b01: sendRequest(1'b1, 1'b0, a, r[6:4], 64'h0);
        2'b10: sendRequest(1'b0, 1'b1, a, r[6:4], {$random(seed), $random(seed)});
        // both strobes, handled as a store
        default: sendRequest(1'b1, 1'b1, a, r[6:4], {$random(seed), $random(seed)});
      endcase
      lastAddr = a;
    end
  endtask

  // run limit from the number of requests plus idle and drain cycles
  initial begin
    #((totalRequests + 20) * clkPeriod);
    $display("watchdog expired, the run hung before all loads returned");
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    seed       = 32'h7c8f_78b6;
    cycleCount = 0;
    rstN       = 1'b0;
    memRd      = 1'b0;
    memWr      = 1'b0;
    addr       = '0;
    memOp      = opD;
    wrData     = '0;
    testReset();
    testDouble();
    testByteLanes();
    testExtension();
    testAlignment();
    testStream();
    // let the last loads leave the pipeline
    while (expDataQ.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* verilog.f */
design/memOpPkg.sv
design/lsuPkg.sv
design/accessDecode.sv
design/dataMem.sv
design/loadFormat.sv
design/lsuTop.sv
bench/lsuTb.sv
